/* list.f */
ttc_pkg.sv
ttc_bus_decode.sv
ttc_prescaler.sv
ttc_counter_lite.sv
ttc_intr_status.sv
ttc_top.sv
tb_ttc_checker.sv
tb_ttc.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the timer/counter regression with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ttc -Mdir obj_dir -f list.f

./obj_dir/Vtb_ttc 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation completed without a reported failure"

/* tb_ttc.sv */
// Timer/counter testbench top: clock, reset, stimulus table, apply loop, watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module tb_ttc
  import ttc_pkg::*;
();

  localparam int max_rows     = 64;
  localparam int reset_cycles = 16;
  localparam int row_cycles   = 3;  // Setup, access, back to idle

  logic        pclk17;
  logic        n_p_reset17;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [5:0]  paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        irq;

  // Request to the checker for the current read
  logic        check_en;
  logic [15:0] exp_data;
  logic        exp_irq;
  string       test_name;
  int          checks;
  int          errors;

  // Stimulus table, one row per access
  string       name_tab [max_rows];
  logic        wr_tab   [max_rows];
  logic [5:0]  addr_tab [max_rows];
  logic [15:0] data_tab [max_rows];
  int          idle_tab [max_rows];
  logic [15:0] exp_tab  [max_rows];
  logic        irq_tab  [max_rows];
  int          n_rows      = 0;
  int          n_reads     = 0;
  int          idle_sum    = 0;
  integer      seed;
  logic        table_ready = 1'b0;

  ttc_top ttc_top_inst (
    .pclk17, .n_p_reset17, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .irq
  );

  tb_ttc_checker checker_inst (
    .pclk17, .psel, .penable, .pwrite, .prdata, .irq,
    .check_en, .exp_data, .exp_irq, .test_name, .checks, .errors
  );

  initial
  begin
    pclk17 = 1'b0;
    forever #5 pclk17 = ~pclk17;  // 10 ns period
  end

  task automatic add_row(input string name, input logic wr, input logic [5:0] addr,
                         input logic [15:0] data, input int idle,
                         input logic [15:0] exp, input logic exp_i);
    name_tab[n_rows] = name;
    wr_tab[n_rows]   = wr;
    addr_tab[n_rows] = addr;
    data_tab[n_rows] = data;
    idle_tab[n_rows] = idle;
    exp_tab[n_rows]  = exp;
    irq_tab[n_rows]  = exp_i;
    idle_sum         = idle_sum + idle;
    n_rows++;
    if (!wr)
      n_reads++;
  endtask

  // Random value written then read back through the register mask
  task automatic add_readback(input string name, input logic [5:0] addr,
                              input logic [15:0] mask);
    logic [31:0] rnd;
    rnd = $random(seed);
    add_row({name, "_wr"}, 1'b1, addr, rnd[15:0], 0, 16'h0000, 1'b0);
    add_row({name, "_rd"}, 1'b0, addr, 16'h0000, 0, rnd[15:0] & mask, 1'b0);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus table; a row lasts its idle cycles plus row_cycles
  // ------------------------------------------------------------------------
  task automatic build_table();
    int ovf_idle;
    int iv;
    int int_idle;
    int presc_div;
    int presc_idle;
    ovf_idle   = 20;
    iv         = 5;
    int_idle   = 10;
    presc_div  = 3;
    presc_idle = 13;
    // Reset values, hole at 0x24 reads zero
    add_row("reset_ctrl", 1'b0, addr_ctrl, 16'h0000, 0, 16'h0001, 1'b0);
    add_row("reset_interval", 1'b0, addr_interval, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_match_1", 1'b0, addr_match_1, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_match_2", 1'b0, addr_match_2, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_match_3", 1'b0, addr_match_3, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_count", 1'b0, addr_count, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_prescale", 1'b0, addr_prescale, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_status", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_enable", 1'b0, addr_intr_enable, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("reset_hole", 1'b0, 6'h24, 16'h0000, 0, 16'h0000, 1'b0);
    // Readback, counter still held off
    add_readback("rb_interval", addr_interval, 16'hffff);
    add_readback("rb_match_1", addr_match_1, 16'hffff);
    add_readback("rb_match_2", addr_match_2, 16'hffff);
    add_readback("rb_match_3", addr_match_3, 16'hffff);
    add_readback("rb_prescale", addr_prescale, 16'h001f);
    add_readback("rb_enable", addr_intr_enable, 16'h001f);
    add_row("rb_ctrl_wr", 1'b1, addr_ctrl, 16'h0061, 0, 16'h0000, 1'b0);  // Wave bits, dis
    add_row("rb_ctrl_rd", 1'b0, addr_ctrl, 16'h0000, 0, 16'h0061, 1'b0);
    add_row("presc_off", 1'b1, addr_prescale, 16'h0000, 0, 16'h0000, 1'b0);
    // Overflow decrement, one step per cycle from the run write to the stop write
    add_row("ovf_restart", 1'b1, addr_ctrl, 16'h0015, 0, 16'h0000, 1'b0);
    add_row("ovf_run", 1'b1, addr_ctrl, 16'h0004, 2, 16'h0000, 1'b0);
    add_row("ovf_stop", 1'b1, addr_ctrl, 16'h0005, ovf_idle, 16'h0000, 1'b0);
    add_row("ovf_count", 1'b0, addr_count, 16'h0000, 0,
            16'hffff - 16'(ovf_idle + row_cycles), 1'b0);
    add_row("ovf_status", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0000, 1'b0);
    // Interval increment wraps past iv, interval irq enabled
    add_row("int_mask", 1'b1, addr_intr_enable, 16'h0002, 0, 16'h0000, 1'b0);
    add_row("int_interval", 1'b1, addr_interval, 16'(iv), 0, 16'h0000, 1'b0);
    add_row("int_restart", 1'b1, addr_ctrl, 16'h0013, 0, 16'h0000, 1'b0);
    add_row("int_run", 1'b1, addr_ctrl, 16'h0002, 2, 16'h0000, 1'b0);
    add_row("int_stop", 1'b1, addr_ctrl, 16'h0003, int_idle, 16'h0000, 1'b0);
    add_row("int_count", 1'b0, addr_count, 16'h0000, 0,
            16'((int_idle + row_cycles) % (iv + 1)), 1'b1);
    add_row("int_status", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0002, 1'b1);
    add_row("int_cleared", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0000, 1'b0);
    // Match 2 at 3, the other two out of reach
    add_row("match_1_far", 1'b1, addr_match_1, 16'h8000, 0, 16'h0000, 1'b0);
    add_row("match_3_far", 1'b1, addr_match_3, 16'h9000, 0, 16'h0000, 1'b0);
    add_row("match_2_set", 1'b1, addr_match_2, 16'h0003, 0, 16'h0000, 1'b0);
    add_row("match_mask", 1'b1, addr_intr_enable, 16'h0008, 0, 16'h0000, 1'b0);
    add_row("match_restart", 1'b1, addr_ctrl, 16'h0019, 0, 16'h0000, 1'b0);
    add_row("match_run", 1'b1, addr_ctrl, 16'h0008, 2, 16'h0000, 1'b0);
    add_row("match_stop", 1'b1, addr_ctrl, 16'h0009, 6, 16'h0000, 1'b0);
    add_row("match_count", 1'b0, addr_count, 16'h0000, 0, 16'(6 + row_cycles), 1'b1);
    add_row("match_status", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0008, 1'b1);
    add_row("match_cleared", 1'b0, addr_intr_status, 16'h0000, 0, 16'h0000, 1'b0);
    // Prescaler, whole periods from the prescale write to the stop write
    add_row("presc_restart", 1'b1, addr_ctrl, 16'h0011, 0, 16'h0000, 1'b0);
    add_row("presc_set", 1'b1, addr_prescale, 16'(16 + presc_div), 2, 16'h0000, 1'b0);
    add_row("presc_run", 1'b1, addr_ctrl, 16'h0000, 0, 16'h0000, 1'b0);
    add_row("presc_stop", 1'b1, addr_ctrl, 16'h0001, presc_idle, 16'h0000, 1'b0);
    add_row("presc_count", 1'b0, addr_count, 16'h0000, 0,
            16'((2 * row_cycles + presc_idle) / (presc_div + 1)), 1'b0);
  endtask

  // One APB transfer, setup then access, inputs 1 ns after the edge
  task automatic apply_row(input int i);
    repeat (idle_tab[i]) @(posedge pclk17);
    @(posedge pclk17);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr_tab[i];
    paddr   = addr_tab[i];
    pwdata  = wr_tab[i] ? data_tab[i] : 16'h0000;
    @(posedge pclk17);
    #1;
    penable = 1'b1;
    if (!wr_tab[i])
    begin
      test_name = name_tab[i];
      exp_data  = exp_tab[i];
      exp_irq   = irq_tab[i];
      check_en  = 1'b1;  // Checker samples mid cycle
    end
    @(posedge pclk17);
    #1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    check_en = 1'b0;
  endtask

  initial
  begin
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    n_p_reset17 = 1'b0;
    check_en    = 1'b0;
    exp_data    = '0;
    exp_irq     = 1'b0;
    test_name   = "";
    seed        = 32'hd85e_87d5;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge pclk17);
    #1;
    n_p_reset17 = 1'b1;
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    @(posedge pclk17);
    #1;
    $display("Summary: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0 && checks == n_reads)
      $display("Regression passed");
    else
    begin
      if (checks != n_reads)
        $display("Only %0d of %0d reads were checked", checks, n_reads);
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog, budget of four cycles per row plus idle and reset
  initial
  begin : watchdog
    int limit;
    wait (table_ready);
    limit = reset_cycles + idle_sum + n_rows * 4;
    repeat (limit) @(posedge pclk17);
    $display("Watchdog expired after %0d cycles, the stimulus did not complete", limit);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_ttc_checker.sv */
// Testbench checker: compares read data and irq in each requested APB read access phase
`timescale 1ns/100ps
`default_nettype none

module tb_ttc_checker (
  input  wire         pclk17,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [15:0] prdata,
  input  wire         irq,
  input  wire         check_en,
  input  wire  [15:0] exp_data,
  input  wire         exp_irq,
  input  string       test_name,
  output int          checks,
  output int          errors
);

  int n_checks = 0;
  int n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  // Sampled on the falling edge, prdata and irq settled
  always @(negedge pclk17)
  begin
    logic bad;
    bad = 1'b0;
    if (check_en && psel && penable && !pwrite)
    begin
      if (prdata !== exp_data)
      begin
        $display("** Error: %s prdata expected 0x%04h actual 0x%04h",
                 test_name, exp_data, prdata);
        bad = 1'b1;
      end
      if (irq !== exp_irq)
      begin
        $display("** Error: %s irq expected %0b actual %0b", test_name, exp_irq, irq);
        bad = 1'b1;
      end
      n_checks++;
      if (bad)
        n_errors++;
      else
        $display("ok    %s prdata 0x%04h irq %0b", test_name, prdata, irq);
    end
  end

endmodule

`default_nettype wire

/* ttc_top.sv */
// Timer/counter top: APB decode, prescaler, counter and interrupt stages in a row
`timescale 1ns/100ps
`default_nettype none

module ttc_top
  import ttc_pkg::*;
(
  input  wire         pclk17,
  input  wire         n_p_reset17,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [5:0]  paddr,
  input  wire  [15:0] pwdata,
  output logic [15:0] prdata,
  output logic        irq
);

  ttc_wdata_u  wdata;
  logic        ctrl_sel, interval_sel, match_1_sel, match_2_sel, match_3_sel;
  logic        prescale_sel, intr_enable_sel, status_rd;
  logic [6:0]  ctrl_val;
  logic [15:0] interval_val, match_1_val, match_2_val, match_3_val, count_val;
  logic [4:0]  prescale_val, intr_status_val, intr_enable_val;
  logic        count_en;
  logic        interval_intr, overflow_intr;
  logic [2:0]  match_intr;

  // Stage 1, bus
  ttc_bus_decode u_bus_decode (
    .pclk17, .n_p_reset17, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .wdata, .ctrl_sel, .interval_sel, .match_1_sel, .match_2_sel, .match_3_sel,
    .prescale_sel, .intr_enable_sel, .status_rd,
    .ctrl_val, .interval_val, .match_1_val, .match_2_val, .match_3_val,
    .count_val, .prescale_val, .intr_status_val, .intr_enable_val
  );

  // Stage 2, count enable
  ttc_prescaler u_prescaler (
    .pclk17, .n_p_reset17, .wdata, .prescale_sel, .prescale_val, .count_en
  );

  // Stage 3, counter
  ttc_counter_lite u_counter_lite (
    .pclk17, .n_p_reset17, .wdata, .count_en,
    .ctrl_sel, .interval_sel, .match_1_sel, .match_2_sel, .match_3_sel,
    .count_val, .ctrl_val, .interval_val, .match_1_val, .match_2_val, .match_3_val,
    .interval_intr, .overflow_intr, .match_intr
  );

  // Stage 4, interrupts
  ttc_intr_status u_intr_status (
    .pclk17, .n_p_reset17, .wdata, .intr_enable_sel, .status_rd,
    .interval_intr, .overflow_intr, .match_intr,
    .intr_status_val, .intr_enable_val, .irq
  );

endmodule

`default_nettype wire

/* ttc_intr_status.sv */
// Interrupt stage: sticky status with clear on read, enable mask and registered irq
`timescale 1ns/100ps
`default_nettype none

module ttc_intr_status
  import ttc_pkg::*;
(
  input  wire                    pclk17,
  input  wire                    n_p_reset17,
  input  ttc_wdata_u             wdata,
  input  wire                    intr_enable_sel,
  input  wire                    status_rd,
  input  wire                    interval_intr,
  input  wire                    overflow_intr,
  input  wire  [2:0]             match_intr,
  output logic [intr_width-1:0]  intr_status_val,
  output logic [intr_width-1:0]  intr_enable_val,
  output logic                   irq
);

  logic [intr_width-1:0] status;
  logic [intr_width-1:0] enable;
  logic [intr_width-1:0] events;  // Event levels in status layout

  assign intr_status_val = status;
  assign intr_enable_val = enable;

  always_comb
  begin
    events                          = '0;
    events[intr_overflow_bit]       = overflow_intr;
    events[intr_interval_bit]       = interval_intr;
    events[intr_match_bits +: 3]    = match_intr;
  end

  // --------------------------------------------------------------------------
  // Status, mask and irq
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk17 or negedge n_p_reset17)
  begin
    if (!n_p_reset17)
    begin
      status <= '0;
      enable <= '0;
      irq    <= 1'b0;
    end
    else
    begin
      // Read clears, a same cycle event still sets
      status <= (status_rd ? '0 : status) | events;

      if (intr_enable_sel)
        enable <= wdata.raw[intr_width-1:0];

      irq <= |(status & enable);  // One cycle behind status
    end
  end

endmodule

`default_nettype wire

/* ttc_counter_lite.sv */
// Timer counter core: control, interval and match registers with the up/down count
`timescale 1ns/100ps
`default_nettype none

module ttc_counter_lite
  import ttc_pkg::*;
(
  input  wire         pclk17,
  input  wire         n_p_reset17,
  input  ttc_wdata_u  wdata,
  input  wire         count_en,
  input  wire         ctrl_sel,
  input  wire         interval_sel,
  input  wire         match_1_sel,
  input  wire         match_2_sel,
  input  wire         match_3_sel,
  output logic [15:0] count_val,
  output logic [6:0]  ctrl_val,
  output logic [15:0] interval_val,
  output logic [15:0] match_1_val,
  output logic [15:0] match_2_val,
  output logic [15:0] match_3_val,
  output logic        interval_intr,
  output logic        overflow_intr,
  output logic [2:0]  match_intr
);

  logic [6:0]  ctrl_reg;
  logic [15:0] interval_reg;
  logic [15:0] match_1_reg;
  logic [15:0] match_2_reg;
  logic [15:0] match_3_reg;
  logic [15:0] count;
  logic        counting;     // Set once the first count has happened
  logic        restart_clr;  // Pulse after a restart load
  logic [15:0] restart_val;
  logic [15:0] next_count;
  logic        ev_ok;

  assign ctrl_val     = ctrl_reg;
  assign interval_val = interval_reg;
  assign match_1_val  = match_1_reg;
  assign match_2_val  = match_2_reg;
  assign match_3_val  = match_3_reg;
  assign count_val    = count;

  // --------------------------------------------------------------------------
  // Event outputs, levels while the count sits on the event value
  // --------------------------------------------------------------------------
  assign ev_ok = counting & ~ctrl_reg[ctrl_restart_bit] & ~ctrl_reg[ctrl_dis_bit];

  assign interval_intr = ctrl_reg[ctrl_interval_bit]  & (count == 16'h0000) & ev_ok;
  assign overflow_intr = ~ctrl_reg[ctrl_interval_bit] & (count == 16'h0000) & ev_ok;
  assign match_intr[0] = ctrl_reg[ctrl_match_bit] & (count == match_1_reg) & ev_ok;
  assign match_intr[1] = ctrl_reg[ctrl_match_bit] & (count == match_2_reg) & ev_ok;
  assign match_intr[2] = ctrl_reg[ctrl_match_bit] & (count == match_3_reg) & ev_ok;

  // Register writes; the restart bit also clears itself
  always_ff @(posedge pclk17 or negedge n_p_reset17)
  begin
    if (!n_p_reset17)
    begin
      ctrl_reg     <= ctrl_reset_value;
      interval_reg <= '0;
      match_1_reg  <= '0;
      match_2_reg  <= '0;
      match_3_reg  <= '0;
    end
    else
    begin
      if (ctrl_sel)
      begin
        ctrl_reg[ctrl_dis_bit]      <= wdata.ctrl.dis;
        ctrl_reg[ctrl_interval_bit] <= wdata.ctrl.interval;
        ctrl_reg[ctrl_decr_bit]     <= wdata.ctrl.decr;
        ctrl_reg[ctrl_match_bit]    <= wdata.ctrl.match;
        ctrl_reg[ctrl_restart_bit]  <= wdata.ctrl.restart;
        ctrl_reg[ctrl_wave_dis_bit] <= wdata.ctrl.wave_dis;  // Kept for readback
        ctrl_reg[ctrl_wave_pol_bit] <= wdata.ctrl.wave_pol;
      end
      else if (restart_clr)
        ctrl_reg[ctrl_restart_bit] <= 1'b0;

      if (interval_sel) interval_reg <= wdata.raw;
      if (match_1_sel)  match_1_reg  <= wdata.raw;
      if (match_2_sel)  match_2_reg  <= wdata.raw;
      if (match_3_sel)  match_3_reg  <= wdata.raw;
    end
  end

  // Restart load value, depends on direction and mode
  always_comb
  begin
    if (!ctrl_reg[ctrl_decr_bit])
      restart_val = 16'h0000;
    else if (ctrl_reg[ctrl_interval_bit])
      restart_val = interval_reg;
    else
      restart_val = 16'hffff;
  end

  // --------------------------------------------------------------------------
  // Next count for the four mode combinations
  // --------------------------------------------------------------------------
  always_comb
  begin
    case ({ctrl_reg[ctrl_interval_bit], ctrl_reg[ctrl_decr_bit]})
      2'b11:   next_count = (count == 16'h0000) ? interval_reg : count - 16'h0001;
      2'b10:   next_count = (count >= interval_reg) ? 16'h0000 : count + 16'h0001;
      2'b01:   next_count = count - 16'h0001; // Wraps through 0xffff
      default: next_count = count + 16'h0001;
    endcase
  end

  always_ff @(posedge pclk17 or negedge n_p_reset17)
  begin
    if (!n_p_reset17)
    begin
      count       <= '0;
      counting    <= 1'b0;
      restart_clr <= 1'b0;
    end
    else
    begin
      restart_clr <= 1'b0;
      if (count_en)
      begin
        if (ctrl_reg[ctrl_restart_bit])
        begin
          count       <= restart_val;
          counting    <= 1'b0;
          restart_clr <= 1'b1;  // Drop the restart bit next edge
        end
        else if (!ctrl_reg[ctrl_dis_bit])
        begin
          count    <= next_count;
          counting <= 1'b1;
        end
      end
    end
  end

  // Interval up count stays inside the interval once a step has been taken
  assert property (@(posedge pclk17) disable iff (!n_p_reset17)
    (ctrl_reg[ctrl_interval_bit] && !ctrl_reg[ctrl_decr_bit] && !ctrl_reg[ctrl_dis_bit]
     && counting && count_en && !interval_sel && !ctrl_sel)
    |=> (count <= interval_reg));

endmodule

`default_nettype wire

/* ttc_prescaler.sv */
// Prescaler: divides pclk17 into count enable pulses from the prescale register
`timescale 1ns/100ps
`default_nettype none

module ttc_prescaler
  import ttc_pkg::*;
(
  input  wire         pclk17,
  input  wire         n_p_reset17,
  input  ttc_wdata_u  wdata,
  input  wire         prescale_sel,
  output logic [4:0]  prescale_val,
  output logic        count_en
);

  logic [4:0]                 presc_reg;  // {enable, divide}
  logic [presc_div_width-1:0] div_cnt;    // Cycles left to next pulse
  logic                       presc_en;
  logic [presc_div_width-1:0] div_val;

  assign presc_en     = presc_reg[presc_en_bit];
  assign div_val      = presc_reg[presc_div_width-1:0];
  assign prescale_val = presc_reg;

  // Bypass when off, else one pulse per D+1 cycles
  assign count_en = ~presc_en | (div_cnt == '0);

  // --------------------------------------------------------------------------
  // Prescale register and divide counter
  // --------------------------------------------------------------------------
  always_ff @(posedge pclk17 or negedge n_p_reset17)
  begin
    if (!n_p_reset17)
    begin
      presc_reg <= '0;
      div_cnt   <= '0;
    end
    else if (prescale_sel)
    begin
      presc_reg <= wdata.raw[4:0];
      div_cnt   <= wdata.raw[presc_div_width-1:0]; // Period starts at the write
    end
    else if (count_en)
      div_cnt <= div_val;          // Reload after each pulse
    else
      div_cnt <= div_cnt - 1'b1;
  end

  // Pulses are isolated whenever a real divide is in force
  assert property (@(posedge pclk17) disable iff (!n_p_reset17)
    (presc_en && (div_val != '0) && count_en && !prescale_sel) |=> !count_en);

endmodule

`default_nettype wire

/* ttc_bus_decode.sv */
// APB access decode into register select strobes, plus the read data multiplexer
`timescale 1ns/100ps
`default_nettype none

module ttc_bus_decode
  import ttc_pkg::*;
(
  input  wire         pclk17,
  input  wire         n_p_reset17,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [5:0]  paddr,
  input  wire  [15:0] pwdata,
  output logic [15:0] prdata,
  output ttc_wdata_u  wdata,
  output logic        ctrl_sel,
  output logic        interval_sel,
  output logic        match_1_sel,
  output logic        match_2_sel,
  output logic        match_3_sel,
  output logic        prescale_sel,
  output logic        intr_enable_sel,
  output logic        status_rd,
  input  wire  [6:0]  ctrl_val,
  input  wire  [15:0] interval_val,
  input  wire  [15:0] match_1_val,
  input  wire  [15:0] match_2_val,
  input  wire  [15:0] match_3_val,
  input  wire  [15:0] count_val,
  input  wire  [4:0]  prescale_val,
  input  wire  [4:0]  intr_status_val,
  input  wire  [4:0]  intr_enable_val
);

  logic access;  // Access phase, no wait states
  logic wr_acc;
  logic rd_acc;

  assign access = psel & penable;
  assign wr_acc = access & pwrite;
  assign rd_acc = access & ~pwrite;

  assign wdata.raw = pwdata; // Same word, each stage picks its view

  // Write strobes, one per register
  assign ctrl_sel        = wr_acc & (paddr == addr_ctrl);
  assign interval_sel    = wr_acc & (paddr == addr_interval);
  assign match_1_sel     = wr_acc & (paddr == addr_match_1);
  assign match_2_sel     = wr_acc & (paddr == addr_match_2);
  assign match_3_sel     = wr_acc & (paddr == addr_match_3);
  assign prescale_sel    = wr_acc & (paddr == addr_prescale);
  assign intr_enable_sel = wr_acc & (paddr == addr_intr_enable);
  assign status_rd       = rd_acc & (paddr == addr_intr_status); // Clears status

  // Read mux, zero extended, holes read as zero
  always_comb
  begin
    prdata = '0;
    case (paddr)
      addr_ctrl:        prdata = {9'd0, ctrl_val};
      addr_interval:    prdata = interval_val;
      addr_match_1:     prdata = match_1_val;
      addr_match_2:     prdata = match_2_val;
      addr_match_3:     prdata = match_3_val;
      addr_count:       prdata = count_val;
      addr_prescale:    prdata = {11'd0, prescale_val};
      addr_intr_status: prdata = {11'd0, intr_status_val};
      addr_intr_enable: prdata = {11'd0, intr_enable_val};
      default:          prdata = '0;
    endcase
  end

  // No two registers are ever touched by one access
  assert property (@(posedge pclk17) disable iff (!n_p_reset17)
    $onehot0({ctrl_sel, interval_sel, match_1_sel, match_2_sel, match_3_sel,
              prescale_sel, intr_enable_sel, status_rd}));

endmodule

`default_nettype wire

/* ttc_pkg.sv */
// Timer/counter shared definitions: register map, control bits and the bus write word
`default_nettype none

package ttc_pkg;

  // --------------------------------------------------------------------------
  // Register map, word offsets on a 6-bit paddr
  // --------------------------------------------------------------------------
  localparam logic [5:0] addr_ctrl         = 6'h00;
  localparam logic [5:0] addr_interval     = 6'h04;
  localparam logic [5:0] addr_match_1      = 6'h08;
  localparam logic [5:0] addr_match_2      = 6'h0c;
  localparam logic [5:0] addr_match_3      = 6'h10;
  localparam logic [5:0] addr_count        = 6'h14; // Read only
  localparam logic [5:0] addr_prescale     = 6'h18;
  localparam logic [5:0] addr_intr_status  = 6'h1c; // Clear on read
  localparam logic [5:0] addr_intr_enable  = 6'h20;

  // Control register bit positions
  localparam int ctrl_dis_bit      = 0; // Counter disable, active high
  localparam int ctrl_interval_bit = 1; // Interval mode, else overflow
  localparam int ctrl_decr_bit     = 2; // Count down
  localparam int ctrl_match_bit    = 3; // Match events on
  localparam int ctrl_restart_bit  = 4; // Self clearing
  localparam int ctrl_wave_dis_bit = 5; // Stored only
  localparam int ctrl_wave_pol_bit = 6; // Stored only

  localparam logic [6:0] ctrl_reset_value = 7'b000_0001; // Held off out of reset

  // Interrupt status and enable layout
  localparam int intr_width        = 5;
  localparam int intr_overflow_bit = 0;
  localparam int intr_interval_bit = 1;
  localparam int intr_match_bits   = 2; // Base of match 1..3, bits 2 to 4

  // Prescale register layout
  localparam int presc_div_width = 4; // Divide value in the low bits
  localparam int presc_en_bit    = 4;

  // One bus word, seen raw or as the control fields
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [8:0] unused;
      logic       wave_pol;
      logic       wave_dis;
      logic       restart;
      logic       match;
      logic       decr;
      logic       interval;
      logic       dis;
    } ctrl;
  } ttc_wdata_u;

endpackage

`default_nettype wire
